//--- rtl/palette_lookup.sv
`timescale 1ns/100ps

module palette_lookup (
	input  logic                          clk_6m,
	input  logic                          palette_we,
	input  tilegen_cpu_pkg::cpu_addr_t    cpu_addr,
	input  tilegen_cpu_pkg::cpu_data_t    cpu_data,
	input  tilegen_video_pkg::pal_index_t pal_index,
	output logic [7:0]                    dot
);
	import tilegen_video_pkg::*;

	localparam int PAL_BITS = $bits(pal_index_t);
	localparam int PAL_ENTRIES = 2 ** PAL_BITS;

	// one byte per color
	logic [7:0] pal_ram [PAL_ENTRIES];

	// palette powers up black
	initial begin
		for (int i = 0; i < PAL_ENTRIES; i++)
			pal_ram[i] = '0;
	end

	always @(posedge clk_6m) begin
		if (palette_we)
			pal_ram[cpu_addr[PAL_BITS-1:0]] <= cpu_data;
	end

	// last pipe stage
	always_ff @(posedge clk_6m)
		dot <= pal_ram[pal_index];

	// once the pipe carries a known index the dot must be known next cycle
	assert property (@(posedge clk_6m) !$isunknown(pal_index) |=> !$isunknown(dot))
		else $error("dot unknown after a valid palette index");

endmodule

//--- rtl/scroll_address_gen.sv
`timescale 1ns/100ps
`include "tilegen_params.svh"

module scroll_address_gen (
	input  logic                           clk_6m,
	input  logic                           tile_we,
	input  tilegen_cpu_pkg::cpu_addr_t     cpu_addr,
	input  tilegen_cpu_pkg::cpu_data_t     cpu_data,
	input  tilegen_video_pkg::coord_t      scr_x,
	input  tilegen_video_pkg::coord_t      scr_y,
	input  tilegen_video_pkg::coord_t      scroll_x,
	input  tilegen_video_pkg::coord_t      scroll_y,
	output tilegen_video_pkg::tile_code_t  tile_code,
	output tilegen_video_pkg::tile_color_t tile_color,
	output logic [2:0]                     tile_row,
	output logic [2:0]                     tile_col
);
	import tilegen_video_pkg::*;

	localparam int MAP_ENTRIES = `TG_MAP_TILES * `TG_MAP_TILES;
	localparam int ENTRY_BITS = $clog2(MAP_ENTRIES);

	// map entry split by byte lane
	// even byte is the code, odd byte the color
	tile_code_t code_ram [MAP_ENTRIES];
	tile_color_t color_ram [MAP_ENTRIES];

	coord_t map_x;
	coord_t map_y;
	logic [ENTRY_BITS-1:0] read_entry;
	logic [ENTRY_BITS-1:0] write_entry;

	// map powers up blank
	initial begin
		for (int i = 0; i < MAP_ENTRIES; i++) begin
			code_ram[i] = '0;
			color_ram[i] = '0;
		end
	end

	////////////////////
	// scroll
	////////////////////

	// 8-bit adds wrap around the 256 pixel map
	assign map_x = scr_x + scroll_x;
	assign map_y = scr_y + scroll_y;

	// row * 32 + column
	assign read_entry = {map_y[7:3], map_x[7:3]};

	// byte offset 2i / 2i+1
	assign write_entry = cpu_addr[ENTRY_BITS:1];

	always @(posedge clk_6m) begin
		if (tile_we) begin
			if (cpu_addr[0])
				color_ram[write_entry] <= cpu_data[3:0];
			else
				code_ram[write_entry] <= cpu_data[5:0];
		end
	end

	// entry plus position inside the tile
	// lands one cycle after scr_x/scr_y
	always_ff @(posedge clk_6m) begin
		tile_code <= code_ram[read_entry];
		tile_color <= color_ram[read_entry];
		tile_row <= map_y[2:0];
		tile_col <= map_x[2:0];
	end

	// strobe only fires for the two map windows below 0x1000
	assert property (@(posedge clk_6m) tile_we |-> (cpu_addr[13:12] == 2'b00))
		else $error("tile map write outside the map window");

endmodule

//--- rtl/tile_pixel_gen.sv
`timescale 1ns/100ps
`include "tilegen_params.svh"

module tile_pixel_gen (
	input  logic                           clk_6m,
	input  logic                           pattern_we,
	input  tilegen_cpu_pkg::cpu_addr_t     cpu_addr,
	input  tilegen_cpu_pkg::cpu_data_t     cpu_data,
	input  tilegen_video_pkg::tile_code_t  tile_code,
	input  tilegen_video_pkg::tile_color_t tile_color,
	input  logic [2:0]                     tile_row,
	input  logic [2:0]                     tile_col,
	input  tilegen_video_pkg::layer_pri_t  layer_pri,
	input  logic                           layer_enable,
	input  tilegen_video_pkg::pal_index_t  chain_index_in,
	input  tilegen_video_pkg::layer_pri_t  chain_pri_in,
	input  logic                           chain_opaque_in,
	output tilegen_video_pkg::pal_index_t  chain_index_out,
	output tilegen_video_pkg::layer_pri_t  chain_pri_out,
	output logic                           chain_opaque_out
);
	import tilegen_video_pkg::*;

	localparam int PATTERN_ROWS = `TG_TILE_CODES * 8;
	localparam int ROW_BITS = $clog2(PATTERN_ROWS);

	// three bit planes with one byte per tile row
	// plane 3 of the cpu layout has no storage
	logic [7:0] plane_ram [3][PATTERN_ROWS];

	logic [ROW_BITS-1:0] write_row;
	logic [ROW_BITS-1:0] read_row;
	logic [7:0] plane_q [3];
	tile_color_t color_q;
	logic [2:0] col_q;
	logic [2:0] bit_sel;
	pixel_t pix;
	logic take;

	// patterns power up transparent
	initial begin
		for (int p = 0; p < 3; p++) begin
			for (int r = 0; r < PATTERN_ROWS; r++)
				plane_ram[p][r] = '0;
		end
	end

	// byte code * 32 + row * 4 + plane
	assign write_row = cpu_addr[ROW_BITS+1:2];
	assign read_row = {tile_code, tile_row};

	always @(posedge clk_6m) begin
		if (pattern_we && cpu_addr[1:0] != 2'd3)
			plane_ram[cpu_addr[1:0]][write_row] <= cpu_data;
	end

	// second pipe stage
	// color and column follow the plane bytes
	always_ff @(posedge clk_6m) begin
		for (int p = 0; p < 3; p++)
			plane_q[p] <= plane_ram[p][read_row];
		color_q <= tile_color;
		col_q <= tile_col;
	end

	////////////////////
	// pixel and merge
	////////////////////

	// leftmost pixel is bit 7 and plane 2 is the msb
	assign bit_sel = 3'd7 - col_q;
	assign pix = {plane_q[2][bit_sel], plane_q[1][bit_sel], plane_q[0][bit_sel]};

	// ties go to the later stage in the chain
	assign take = layer_enable && (pix != '0) &&
		(!chain_opaque_in || (layer_pri >= chain_pri_in));

	assign chain_index_out = take ? {color_q, pix} : chain_index_in;
	assign chain_pri_out = take ? layer_pri : chain_pri_in;
	assign chain_opaque_out = take ? 1'b1 : chain_opaque_in;

	// an opaque chain handed over by the previous layer carries a visible pixel
	assert property (@(posedge clk_6m)
		chain_opaque_in |-> (chain_index_in[2:0] != '0))
		else $error("opaque chain arrived with a transparent pixel");

endmodule

//--- rtl/tilegen_control.sv
`timescale 1ns/100ps
`include "tilegen_params.svh"

module tilegen_control (
	input  logic                          clk_6m,
	input  logic                          reset,
	input  tilegen_cpu_pkg::cpu_addr_t    cpu_addr,
	input  tilegen_cpu_pkg::cpu_data_t    cpu_data,
	input  logic                          cpu_we,
	output logic                          tile_we0,
	output logic                          tile_we1,
	output logic                          pattern_we0,
	output logic                          pattern_we1,
	output logic                          palette_we,
	output tilegen_video_pkg::coord_t     scr_x,
	output tilegen_video_pkg::coord_t     scr_y,
	output tilegen_video_pkg::coord_t     scroll_x0,
	output tilegen_video_pkg::coord_t     scroll_y0,
	output tilegen_video_pkg::coord_t     scroll_x1,
	output tilegen_video_pkg::coord_t     scroll_y1,
	output tilegen_video_pkg::layer_pri_t pri0,
	output tilegen_video_pkg::layer_pri_t pri1,
	output logic                          enable0,
	output logic                          enable1,
	output tilegen_video_pkg::pal_index_t back_index,
	output logic                          dot_active,
	output logic                          hsync,
	output logic                          vsync
);
	import tilegen_cpu_pkg::*;
	import tilegen_video_pkg::*;

	localparam int H_BITS = $clog2(`TG_H_TOTAL);
	localparam int V_BITS = $clog2(`TG_V_TOTAL);
	localparam int LAT = `TG_PIPE_LATENCY;

	logic [H_BITS-1:0] h_count;
	logic [V_BITS-1:0] v_count;
	logic active_now;
	logic hsync_now;
	logic vsync_now;
	logic [LAT-1:0] active_dly;
	logic [LAT-1:0] hsync_dly;
	logic [LAT-1:0] vsync_dly;
	coord_t h_pos;
	coord_t v_pos;
	logic flip;
	logic [1:0] layer_enable;
	cpu_region_e region;
	reg_index_e reg_sel;
	logic reg_we;

	////////////////////
	// raster counters
	////////////////////

	// h wraps at line end and v steps once per line
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			h_count <= '0;
			v_count <= '0;
		end else if (h_count == H_BITS'(`TG_H_TOTAL - 1)) begin
			h_count <= '0;
			if (v_count == V_BITS'(`TG_V_TOTAL - 1))
				v_count <= '0;
			else
				v_count <= v_count + 1'b1;
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	assign active_now = (h_count < `TG_H_ACTIVE) && (v_count < `TG_V_ACTIVE);
	assign hsync_now = (h_count >= `TG_HSYNC_START) &&
		(h_count < `TG_HSYNC_START + `TG_HSYNC_LEN);
	assign vsync_now = (v_count >= `TG_VSYNC_START) &&
		(v_count < `TG_VSYNC_START + `TG_VSYNC_LEN);

	// render coordinates mirror on both axes under flip
	// only meaningful inside the active window
	assign h_pos = h_count[7:0];
	assign v_pos = v_count[7:0];
	assign scr_x = flip ? coord_t'(`TG_H_ACTIVE - 1) - h_pos : h_pos;
	assign scr_y = flip ? coord_t'(`TG_V_ACTIVE - 1) - v_pos : v_pos;

	// flags ride alongside the 3-stage pixel pipe
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			active_dly <= '0;
			hsync_dly <= '0;
			vsync_dly <= '0;
		end else begin
			active_dly <= {active_dly[LAT-2:0], active_now};
			hsync_dly <= {hsync_dly[LAT-2:0], hsync_now};
			vsync_dly <= {vsync_dly[LAT-2:0], vsync_now};
		end
	end

	assign dot_active = active_dly[LAT-1];
	assign hsync = hsync_dly[LAT-1];
	assign vsync = vsync_dly[LAT-1];

	////////////////////
	// cpu decode
	////////////////////

	// 0x0000 maps, 0x1000 patterns, 0x2000 palette, 0x2100 registers
	always_comb begin
		region = REGION_NONE;
		case (cpu_addr[13:11])
			3'b000: region = REGION_MAP0;
			3'b001: region = REGION_MAP1;
			3'b010: region = REGION_PAT0;
			3'b011: region = REGION_PAT1;
			3'b100: begin
				if (cpu_addr[10:7] == 4'b0000)
					region = REGION_PALETTE;
				else if (cpu_addr[10:4] == 7'b0010000)
					region = REGION_REGS;
			end
			default: region = REGION_NONE;
		endcase
	end

	assign tile_we0 = cpu_we && (region == REGION_MAP0);
	assign tile_we1 = cpu_we && (region == REGION_MAP1);
	assign pattern_we0 = cpu_we && (region == REGION_PAT0);
	assign pattern_we1 = cpu_we && (region == REGION_PAT1);
	assign palette_we = cpu_we && (region == REGION_PALETTE);
	assign reg_we = cpu_we && (region == REGION_REGS);
	assign reg_sel = reg_index_e'(cpu_addr[3:0]);

	// control registers
	// both layers start enabled
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			scroll_x0 <= '0;
			scroll_y0 <= '0;
			scroll_x1 <= '0;
			scroll_y1 <= '0;
			pri0 <= '0;
			pri1 <= '0;
			layer_enable <= 2'b11;
			back_index <= '0;
			flip <= 1'b0;
		end else if (reg_we) begin
			case (reg_sel)
				REG_SCROLL_X0:    scroll_x0 <= cpu_data;
				REG_SCROLL_Y0:    scroll_y0 <= cpu_data;
				REG_SCROLL_X1:    scroll_x1 <= cpu_data;
				REG_SCROLL_Y1:    scroll_y1 <= cpu_data;
				REG_PRI0:         pri0 <= cpu_data[2:0];
				REG_PRI1:         pri1 <= cpu_data[2:0];
				REG_LAYER_ENABLE: layer_enable <= cpu_data[1:0];
				REG_BACKCOLOR:    back_index <= cpu_data[6:0];
				REG_FLIP:         flip <= cpu_data[0];
				default: ;
			endcase
		end
	end

	assign enable0 = layer_enable[0];
	assign enable1 = layer_enable[1];

	// sync pulses stay clear of visible dots
	assert property (@(posedge clk_6m) disable iff (reset)
		dot_active |-> !(hsync || vsync))
		else $error("sync pulse inside the active window");

endmodule

//--- rtl/tilegen_cpu_pkg.sv
package tilegen_cpu_pkg;

	// 16K byte CPU window
	typedef logic [13:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;

	// decoded address regions
	typedef enum logic [2:0] {
		REGION_MAP0,
		REGION_MAP1,
		REGION_PAT0,
		REGION_PAT1,
		REGION_PALETTE,
		REGION_REGS,
		REGION_NONE
	} cpu_region_e;

	// register offsets above 0x2100
	typedef enum logic [3:0] {
		REG_SCROLL_X0    = 4'd0,
		REG_SCROLL_Y0    = 4'd1,
		REG_SCROLL_X1    = 4'd2,
		REG_SCROLL_Y1    = 4'd3,
		REG_PRI0         = 4'd4,
		REG_PRI1         = 4'd5,
		REG_LAYER_ENABLE = 4'd6,
		REG_BACKCOLOR    = 4'd7,
		REG_FLIP         = 4'd8
	} reg_index_e;

endpackage

//--- rtl/tilegen_params.svh
`ifndef TILEGEN_PARAMS_SVH
`define TILEGEN_PARAMS_SVH

// visible raster and full frame, in pixels and lines
`define TG_H_ACTIVE 256
`define TG_V_ACTIVE 224
`define TG_H_TOTAL 320
`define TG_V_TOTAL 240

// sync pulses sit inside the blanking interval
`define TG_HSYNC_START 272
`define TG_HSYNC_LEN 24
`define TG_VSYNC_START 228
`define TG_VSYNC_LEN 4

// square tile map, codes index the pattern table
`define TG_MAP_TILES 32
`define TG_TILE_CODES 64

// raster position to registered dot
`define TG_PIPE_LATENCY 3

`endif

//--- rtl/tilegen_subsystem.sv
`timescale 1ns/100ps

module tilegen_subsystem (
	input  logic                       clk_6m,
	input  logic                       reset,
	input  tilegen_cpu_pkg::cpu_addr_t cpu_addr,
	input  tilegen_cpu_pkg::cpu_data_t cpu_data,
	input  logic                       cpu_we,
	output logic [7:0]                 dot,
	output logic                       dot_active,
	output logic                       hsync,
	output logic                       vsync
);
	import tilegen_video_pkg::*;

	// table write strobes
	logic tile_we0;
	logic tile_we1;
	logic pattern_we0;
	logic pattern_we1;
	logic palette_we;

	// raster and layer settings
	coord_t scr_x;
	coord_t scr_y;
	coord_t scroll_x0;
	coord_t scroll_y0;
	coord_t scroll_x1;
	coord_t scroll_y1;
	layer_pri_t pri0;
	layer_pri_t pri1;
	logic enable0;
	logic enable1;
	pal_index_t back_index;

	// per-layer tile entries
	tile_code_t tile_code0;
	tile_code_t tile_code1;
	tile_color_t tile_color0;
	tile_color_t tile_color1;
	logic [2:0] tile_row0;
	logic [2:0] tile_row1;
	logic [2:0] tile_col0;
	logic [2:0] tile_col1;

	// chain between layer 0 and layer 1, then into the palette
	pal_index_t mid_index;
	layer_pri_t mid_pri;
	logic mid_opaque;
	pal_index_t final_index;

	tilegen_control u_control (
		.clk_6m(clk_6m),
		.reset(reset),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.cpu_we(cpu_we),
		.tile_we0(tile_we0),
		.tile_we1(tile_we1),
		.pattern_we0(pattern_we0),
		.pattern_we1(pattern_we1),
		.palette_we(palette_we),
		.scr_x(scr_x),
		.scr_y(scr_y),
		.scroll_x0(scroll_x0),
		.scroll_y0(scroll_y0),
		.scroll_x1(scroll_x1),
		.scroll_y1(scroll_y1),
		.pri0(pri0),
		.pri1(pri1),
		.enable0(enable0),
		.enable1(enable1),
		.back_index(back_index),
		.dot_active(dot_active),
		.hsync(hsync),
		.vsync(vsync)
	);

	scroll_address_gen u_scroll0 (
		.clk_6m(clk_6m),
		.tile_we(tile_we0),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.scr_x(scr_x),
		.scr_y(scr_y),
		.scroll_x(scroll_x0),
		.scroll_y(scroll_y0),
		.tile_code(tile_code0),
		.tile_color(tile_color0),
		.tile_row(tile_row0),
		.tile_col(tile_col0)
	);

	scroll_address_gen u_scroll1 (
		.clk_6m(clk_6m),
		.tile_we(tile_we1),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.scr_x(scr_x),
		.scr_y(scr_y),
		.scroll_x(scroll_x1),
		.scroll_y(scroll_y1),
		.tile_code(tile_code1),
		.tile_color(tile_color1),
		.tile_row(tile_row1),
		.tile_col(tile_col1)
	);

	// chain starts at the background color, transparent, priority 0
	tile_pixel_gen u_layer0 (
		.clk_6m(clk_6m),
		.pattern_we(pattern_we0),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.tile_code(tile_code0),
		.tile_color(tile_color0),
		.tile_row(tile_row0),
		.tile_col(tile_col0),
		.layer_pri(pri0),
		.layer_enable(enable0),
		.chain_index_in(back_index),
		.chain_pri_in(3'd0),
		.chain_opaque_in(1'b0),
		.chain_index_out(mid_index),
		.chain_pri_out(mid_pri),
		.chain_opaque_out(mid_opaque)
	);

	// only the index leaves the last stage
	tile_pixel_gen u_layer1 (
		.clk_6m(clk_6m),
		.pattern_we(pattern_we1),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.tile_code(tile_code1),
		.tile_color(tile_color1),
		.tile_row(tile_row1),
		.tile_col(tile_col1),
		.layer_pri(pri1),
		.layer_enable(enable1),
		.chain_index_in(mid_index),
		.chain_pri_in(mid_pri),
		.chain_opaque_in(mid_opaque),
		.chain_index_out(final_index),
		.chain_pri_out(),
		.chain_opaque_out()
	);

	palette_lookup u_palette (
		.clk_6m(clk_6m),
		.palette_we(palette_we),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.pal_index(final_index),
		.dot(dot)
	);

endmodule

//--- rtl/tilegen_video_pkg.sv
package tilegen_video_pkg;

	// 3 bits per pixel
	// value 0 is transparent
	typedef logic [2:0] pixel_t;

	// per-tile color from the map entry
	typedef logic [3:0] tile_color_t;

	// layer priority, higher wins
	typedef logic [2:0] layer_pri_t;

	// palette address {tile color, pixel}
	// also carries the background color
	typedef logic [6:0] pal_index_t;

	// tile code, one of 64 patterns
	typedef logic [5:0] tile_code_t;

	// screen or map coordinate
	// map is 256 pixels wide so this wraps naturally
	typedef logic [7:0] coord_t;

endpackage

//--- test/tilegen_cases.txt
# W addr data  writes one byte (both hex)   C x y dot  expects a dot at screen x y (decimal)
# F scans the next frame and checks every queued dot   E ends the run
# nothing written yet so backcolor 0 reads the blank palette
C 0 0 00
C 255 223 00
C 100 50 00
F
# background moves to palette entry 05
W 2005 a5
W 2107 05
C 0 0 a5
C 255 223 a5
C 100 50 a5
F
# layer 0 pattern code 1 row 2 gives pixels 7 3 1 1 2 2 0 0
W 1028 f0
W 1029 cc
W 102a 80
W 0000 01
W 0001 03
W 201f 9f
W 201b 9b
W 2019 99
W 201a 9a
# scroll wraps map tile (0,0) onto screen x 8 to 15 with row 2 on y 6
W 2100 f8
W 2101 fc
C 8 6 9f
C 9 6 9b
C 10 6 99
C 12 6 9a
C 14 6 a5
C 7 6 a5
C 8 5 a5
F
# layer 1 pattern code 2 row 2 is all pixel 1 except column 1
W 1848 bf
W 1849 00
W 184a 00
W 0842 02
W 0843 05
W 2029 69
W 2102 00
W 2103 04
# layer 0 above layer 1
W 2104 05
W 2105 02
C 8 6 9f
C 9 6 9b
C 12 6 9a
C 14 6 69
F
# layer 1 above layer 0
W 2104 02
W 2105 05
C 8 6 69
C 9 6 9b
C 12 6 69
C 14 6 69
F
# equal priority goes to layer 1
W 2104 04
W 2105 04
C 8 6 69
C 9 6 9b
C 10 6 69
F
# layer 0 only
W 2106 01
C 8 6 9f
C 9 6 9b
C 14 6 a5
F
# layer 1 only
W 2106 02
C 8 6 69
C 9 6 a5
C 14 6 69
F
# both layers with the screen flipped
W 2106 03
W 2108 01
C 247 217 69
C 246 217 9b
C 241 217 69
C 8 6 a5
F
E

//--- test/tilegen_subsystem_tb.sv
`timescale 1ns/100ps
`include "tilegen_params.svh"

module tilegen_subsystem_tb;
	import tilegen_cpu_pkg::*;

	localparam int TIMEOUT_CYCLES = 200000;
	localparam int SCREEN_DOTS = `TG_H_ACTIVE * `TG_V_ACTIVE;

	logic clk_6m = 1'b0;
	logic reset;
	cpu_addr_t cpu_addr;
	cpu_data_t cpu_data;
	logic cpu_we;
	logic [7:0] dot;
	logic dot_active;
	logic hsync;
	logic vsync;

	// expected dots for the next frame keyed by y * 256 + x
	logic [7:0] exp_dot [SCREEN_DOTS];
	bit exp_valid [SCREEN_DOTS];
	int exp_keys [$];

	int fd;
	int error_count;
	int check_count;
	bit aborted;

	tilegen_subsystem u_tilegen_subsystem (
		.clk_6m(clk_6m),
		.reset(reset),
		.cpu_addr(cpu_addr),
		.cpu_data(cpu_data),
		.cpu_we(cpu_we),
		.dot(dot),
		.dot_active(dot_active),
		.hsync(hsync),
		.vsync(vsync)
	);

	// 100 ns pixel clock
	always #50 clk_6m = ~clk_6m;

	////////////////////
	// bus and case file
	////////////////////

	// one byte write
	// strobe stays up until the next bus action
	task automatic bus_write(input cpu_addr_t addr, input cpu_data_t data);
		@(posedge clk_6m);
		cpu_addr <= addr;
		cpu_data <= data;
		cpu_we <= 1'b1;
	endtask

	task automatic bus_idle();
		@(posedge clk_6m);
		cpu_we <= 1'b0;
	endtask

	// rest of a comment line
	task automatic skip_line();
		int ch;
		ch = $fgetc(fd);
		while (ch != "\n" && ch != -1)
			ch = $fgetc(fd);
	endtask

	task automatic report_timeout(input string what);
		error_count++;
		aborted = 1'b1;
		$display("timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
	endtask

	task automatic add_expect(input int x, input int y, input logic [7:0] value);
		int key;
		if (x < 0 || x >= `TG_H_ACTIVE || y < 0 || y >= `TG_V_ACTIVE) begin
			error_count++;
			$display("expected dot at %0d,%0d lies outside the screen", x, y);
		end else begin
			key = y * `TG_H_ACTIVE + x;
			if (!exp_valid[key])
				exp_keys.push_back(key);
			exp_valid[key] = 1'b1;
			exp_dot[key] = value;
		end
	endtask

	task automatic clear_expect();
		foreach (exp_keys[i])
			exp_valid[exp_keys[i]] = 1'b0;
		exp_keys.delete();
	endtask

	////////////////////
	// frame scanner
	////////////////////

	// outputs are sampled on the falling edge
	task automatic wait_vsync(input logic level);
		int count;
		count = 0;
		do begin
			@(negedge clk_6m);
			count++;
		end while (vsync !== level && count < TIMEOUT_CYCLES);
		if (vsync !== level)
			report_timeout(level ? "vsync to rise" : "vsync to fall");
	endtask

	task automatic scan_frame();
		int x;
		int y;
		int h;
		int key;
		int seen;
		int count;
		bit in_line;
		bit h_known;
		bit hsync_exp;
		bit frame_done;
		x = 0;
		y = 0;
		h = 0;
		seen = 0;
		count = 0;
		in_line = 1'b0;
		h_known = 1'b0;
		frame_done = 1'b0;
		// start from the end of a vsync pulse
		wait_vsync(1'b1);
		if (!aborted)
			wait_vsync(1'b0);
		while (!aborted && !frame_done) begin
			@(negedge clk_6m);
			count++;
			// line position restarts on the first active pixel of each line
			if (dot_active && !in_line) begin
				h = 0;
				h_known = 1'b1;
			end else if (h_known) begin
				h = (h + 1) % `TG_H_TOTAL;
			end
			if (h_known) begin
				hsync_exp = (h >= `TG_HSYNC_START) &&
					(h < `TG_HSYNC_START + `TG_HSYNC_LEN);
				assert (hsync === hsync_exp) else begin
					error_count++;
					$display("error at %0t: hsync at h %0d expected %0b, got %0b",
						$time, h, hsync_exp, hsync);
				end
			end
			if (vsync) begin
				frame_done = 1'b1;
			end else if (dot_active) begin
				key = y * `TG_H_ACTIVE + x;
				if (x < `TG_H_ACTIVE && y < `TG_V_ACTIVE && exp_valid[key]) begin
					seen++;
					check_count++;
					assert (dot === exp_dot[key]) else begin
						error_count++;
						$display("error at %0t: dot(%0d,%0d) expected %02h, got %02h",
							$time, x, y, exp_dot[key], dot);
					end
				end
				x++;
				in_line = 1'b1;
			end else if (in_line) begin
				// line just ended
				assert (x == `TG_H_ACTIVE) else begin
					error_count++;
					$display("line %0d had %0d active pixels instead of %0d",
						y, x, `TG_H_ACTIVE);
				end
				y++;
				x = 0;
				in_line = 1'b0;
			end
			if (!frame_done && count >= TIMEOUT_CYCLES)
				report_timeout("the next vsync");
		end
		if (!aborted) begin
			assert (y == `TG_V_ACTIVE) else begin
				error_count++;
				$display("frame had %0d active lines instead of %0d", y, `TG_V_ACTIVE);
			end
			assert (seen == exp_keys.size()) else begin
				error_count++;
				$display("only %0d of %0d expected dots were reached", seen, exp_keys.size());
			end
		end
		clear_expect();
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		int ch;
		int n;
		int x;
		int y;
		int addr;
		int data;
		bit done;
		reset <= 1'b1;
		cpu_addr <= '0;
		cpu_data <= '0;
		cpu_we <= 1'b0;
		error_count = 0;
		check_count = 0;
		aborted = 1'b0;
		done = 1'b0;
		repeat (16) @(posedge clk_6m);
		reset <= 1'b0;

		fd = $fopen("test/tilegen_cases.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("cannot open test/tilegen_cases.txt");
			done = 1'b1;
		end

		// one command letter per line
		while (!done && !aborted) begin
			ch = $fgetc(fd);
			if (ch == -1) begin
				done = 1'b1;
			end else if (ch == "#") begin
				skip_line();
			end else if (ch == "W") begin
				n = $fscanf(fd, "%h %h", addr, data);
				if (n != 2) begin
					error_count++;
					$display("malformed W command in the case file");
					done = 1'b1;
				end else begin
					bus_write(cpu_addr_t'(addr), cpu_data_t'(data));
				end
			end else if (ch == "C") begin
				n = $fscanf(fd, "%d %d %h", x, y, data);
				if (n != 3) begin
					error_count++;
					$display("malformed C command in the case file");
					done = 1'b1;
				end else begin
					add_expect(x, y, data[7:0]);
				end
			end else if (ch == "F") begin
				bus_idle();
				scan_frame();
			end else if (ch == "E") begin
				done = 1'b1;
			end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
				error_count++;
				$display("unknown command character %0d in the case file", ch);
				done = 1'b1;
			end
		end
		if (fd != 0)
			$fclose(fd);
		bus_idle();

		$display("checked %0d dots, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- tilegen_subsystem.f
+incdir+rtl
rtl/tilegen_video_pkg.sv
rtl/tilegen_cpu_pkg.sv
rtl/tilegen_control.sv
rtl/scroll_address_gen.sv
rtl/tile_pixel_gen.sv
rtl/palette_lookup.sv
rtl/tilegen_subsystem.sv
test/tilegen_subsystem_tb.sv
